/* Bender.yml */
package:
  name: ptp_tod_leaf

sources:
  - include_dirs:
      - design
    files:
      - design/ptp_td_pkg.sv
      - design/td_deserializer.sv
      - design/tod_frame_decoder.sv
      - design/tod_load_ctrl.sv
      - design/tod_counter.sv
      - design/ptp_tod_leaf.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/tb_ptp_tod_leaf.sv

/* design/ptp_td_defs.svh */
// word layout, word indices, period and compare window constants, included by RTL and testbench
`ifndef PTP_TD_DEFS_SVH
`define PTP_TD_DEFS_SVH

// serial word layout
`define TD_WORD_W 16

// word positions within message 0
`define TD_IDX_NS_LO 1
`define TD_IDX_NS_HI 2
`define TD_IDX_S_LO 3
`define TD_IDX_S_MID 4
`define TD_IDX_S_HI 5

// step flag in the ns high word
`define TD_STEP_BIT 15

`define TD_MSG_TOD 0

// local time base
`define TOD_PERIOD_NS 8
`define NS_PER_S 1000000000

// low ns bits ignored by the frame compare
`define TOD_CMP_SHIFT 20
`define PPS_STR_CLEAR_BIT 29
`define MISMATCH_LIMIT 3

`endif

/* design/ptp_td_pkg.sv */
// shared vector types and FSM encoding of the time-of-day leaf, imported by RTL and testbench
`default_nettype none

`include "ptp_td_defs.svh"

package ptp_td_pkg;

    // one received data word
    typedef logic [`TD_WORD_W-1:0] td_word_t;

    // position of a word within its frame
    typedef logic [3:0] td_index_t;

    typedef logic [3:0] msg_id_t;

    // time of day fields
    typedef logic [47:0] tod_sec_t;
    typedef logic [29:0] tod_ns_t;

    // seconds, two zero bits, nanoseconds
    typedef logic [79:0] tod_ts_t;

    typedef logic [1:0] mismatch_cnt_t;

    // serial receiver states
    typedef enum logic [1:0] {
        DESER_IDLE,
        DESER_DATA,
        DESER_CONT
    } deser_state_e;

endpackage

`default_nettype wire

/* design/ptp_tod_leaf.sv */
// top level of the time-of-day leaf, connects receiver, frame decoder, load control and counter
`default_nettype none

module ptp_tod_leaf (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 sdi,
    output wire ptp_td_pkg::tod_ts_t  ts_tod,
    output wire logic                 tod_step,
    output wire logic                 pps,
    output wire logic                 pps_str
);

    import ptp_td_pkg::*;

    // receiver to decoder
    wire td_word_t  word;
    wire td_index_t word_index;
    wire msg_id_t   word_msg;
    wire logic      word_last;
    wire logic      word_valid;

    // decoder to load control
    wire tod_sec_t  frame_sec;
    wire tod_ns_t   frame_ns;
    wire logic      frame_step;
    wire logic      frame_valid;

    // load control and counter
    wire logic      load;
    wire tod_sec_t  load_sec;
    wire tod_ns_t   load_ns;
    wire tod_sec_t  tod_sec;
    wire tod_ns_t   tod_ns;

    td_deserializer td_deserializer_i (
        .clk(clk),
        .rst(rst),
        .sdi(sdi),
        .word(word),
        .word_index(word_index),
        .word_msg(word_msg),
        .word_last(word_last),
        .word_valid(word_valid)
    );

    tod_frame_decoder tod_frame_decoder_i (
        .clk(clk),
        .rst(rst),
        .word(word),
        .word_index(word_index),
        .word_msg(word_msg),
        .word_last(word_last),
        .word_valid(word_valid),
        .frame_sec(frame_sec),
        .frame_ns(frame_ns),
        .frame_step(frame_step),
        .frame_valid(frame_valid)
    );

    tod_load_ctrl tod_load_ctrl_i (
        .clk(clk),
        .rst(rst),
        .frame_sec(frame_sec),
        .frame_ns(frame_ns),
        .frame_step(frame_step),
        .frame_valid(frame_valid),
        .tod_sec(tod_sec),
        .tod_ns(tod_ns),
        .load(load),
        .load_sec(load_sec),
        .load_ns(load_ns)
    );

    tod_counter tod_counter_i (
        .clk(clk),
        .rst(rst),
        .load(load),
        .load_sec(load_sec),
        .load_ns(load_ns),
        .tod_sec(tod_sec),
        .tod_ns(tod_ns),
        .ts_tod(ts_tod),
        .tod_step(tod_step),
        .pps(pps),
        .pps_str(pps_str)
    );

endmodule

`default_nettype wire

/* design/td_deserializer.sv */
// serial time-distribution receiver, turns sdi into indexed words with message id and frame end
`default_nettype none

`include "ptp_td_defs.svh"

module td_deserializer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 sdi,
    output ptp_td_pkg::td_word_t      word,
    output ptp_td_pkg::td_index_t     word_index,
    output ptp_td_pkg::msg_id_t       word_msg,
    output logic                      word_last,
    output logic                      word_valid
);

    import ptp_td_pkg::*;

    deser_state_e state;
    logic [3:0]   bit_cnt;
    td_word_t     shift_reg;
    td_index_t    index;
    msg_id_t      msg;

    always_ff @(posedge clk) begin
        word_valid <= 1'b0;

        case (state)
            DESER_IDLE: begin
                bit_cnt <= '0;
                // wait for start bit
                if (!sdi) begin
                    state <= DESER_DATA;
                end
            end
            DESER_DATA: begin
                // lsb first
                shift_reg <= {sdi, shift_reg[`TD_WORD_W-1:1]};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'(`TD_WORD_W - 1)) begin
                    state <= DESER_CONT;
                end
            end
            DESER_CONT: begin
                word <= shift_reg;
                word_index <= index;
                word_last <= sdi;
                word_valid <= 1'b1;
                // message id lives in word 0
                if (index == '0) begin
                    msg <= shift_reg[3:0];
                    word_msg <= shift_reg[3:0];
                end else begin
                    word_msg <= msg;
                end
                bit_cnt <= '0;
                // a zero here doubles as the next start bit
                if (sdi) begin
                    state <= DESER_IDLE;
                    index <= '0;
                end else begin
                    state <= DESER_DATA;
                    index <= index + 1'b1;
                end
            end
            default: begin
                state <= DESER_IDLE;
            end
        endcase

        if (rst) begin
            state <= DESER_IDLE;
            bit_cnt <= '0;
            index <= '0;
            word_valid <= 1'b0;
        end
    end

    // words are at least 17 bit times apart
    a_word_gap: assert property (@(posedge clk) disable iff (rst) word_valid |=> !word_valid);

endmodule

`default_nettype wire

/* design/tod_counter.sv */
// local time-of-day counter with rollover and pps outputs that the leaf top level loads and reads
`default_nettype none

`include "ptp_td_defs.svh"

module tod_counter (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  load,
    input  wire ptp_td_pkg::tod_sec_t  load_sec,
    input  wire ptp_td_pkg::tod_ns_t   load_ns,
    output ptp_td_pkg::tod_sec_t       tod_sec,
    output ptp_td_pkg::tod_ns_t        tod_ns,
    output ptp_td_pkg::tod_ts_t        ts_tod,
    output logic                       tod_step,
    output logic                       pps,
    output logic                       pps_str
);

    import ptp_td_pkg::*;

    // one extra bit so the rollover compare cannot overflow
    logic [30:0] ns_sum;

    assign ns_sum = {1'b0, tod_ns} + 31'(`TOD_PERIOD_NS);

    assign ts_tod = {tod_sec, 2'b00, tod_ns};

    always_ff @(posedge clk) begin
        tod_step <= 1'b0;
        pps <= 1'b0;

        // stretch ends halfway through the second
        if (tod_ns[`PPS_STR_CLEAR_BIT]) begin
            pps_str <= 1'b0;
        end

        if (load) begin
            tod_sec <= load_sec;
            tod_ns <= load_ns;
            tod_step <= 1'b1;
        end else if (ns_sum >= 31'(`NS_PER_S)) begin
            tod_ns <= tod_ns_t'(ns_sum - 31'(`NS_PER_S));
            tod_sec <= tod_sec + 1'b1;
            pps <= 1'b1;
            pps_str <= 1'b1;
        end else begin
            tod_ns <= tod_ns_t'(ns_sum);
        end

        if (rst) begin
            tod_sec <= '0;
            tod_ns <= '0;
            tod_step <= 1'b0;
            pps <= 1'b0;
            pps_str <= 1'b0;
        end
    end

    // ns stays below one second
    a_ns_range: assert property (@(posedge clk) disable iff (rst)
        tod_ns < tod_ns_t'(`NS_PER_S));

endmodule

`default_nettype wire

/* design/tod_frame_decoder.sv */
// collects the time-of-day words of message 0 into shadow registers and flags complete frames
`default_nettype none

`include "ptp_td_defs.svh"

module tod_frame_decoder (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire ptp_td_pkg::td_word_t   word,
    input  wire ptp_td_pkg::td_index_t  word_index,
    input  wire ptp_td_pkg::msg_id_t    word_msg,
    input  wire logic                   word_last,
    input  wire logic                   word_valid,
    output ptp_td_pkg::tod_sec_t        frame_sec,
    output ptp_td_pkg::tod_ns_t         frame_ns,
    output logic                        frame_step,
    output logic                        frame_valid
);

    import ptp_td_pkg::*;

    // index of the next word a good frame must deliver, 0 when idle
    td_index_t next_idx;
    logic      tod_msg;

    assign tod_msg = (word_msg == msg_id_t'(`TD_MSG_TOD));

    always_ff @(posedge clk) begin
        frame_valid <= 1'b0;

        if (word_valid) begin
            if (!tod_msg) begin
                next_idx <= '0;
                frame_step <= 1'b0;
            end else if (word_index == '0) begin
                next_idx <= td_index_t'(`TD_IDX_NS_LO);
                frame_step <= 1'b0;
            end else if (word_index == next_idx) begin
                next_idx <= next_idx + 1'b1;
                case (word_index)
                    td_index_t'(`TD_IDX_NS_LO): frame_ns[15:0] <= word;
                    td_index_t'(`TD_IDX_NS_HI): begin
                        frame_ns[29:16] <= word[13:0];
                        frame_step <= frame_step | word[`TD_STEP_BIT];
                    end
                    td_index_t'(`TD_IDX_S_LO): frame_sec[15:0] <= word;
                    td_index_t'(`TD_IDX_S_MID): frame_sec[31:16] <= word;
                    td_index_t'(`TD_IDX_S_HI): begin
                        frame_sec[47:32] <= word;
                        frame_valid <= 1'b1;
                        next_idx <= '0;
                    end
                    default: next_idx <= '0;
                endcase
                // frame ended before the last seconds word
                if (word_last && word_index != td_index_t'(`TD_IDX_S_HI)) begin
                    next_idx <= '0;
                    frame_step <= 1'b0;
                end
            end else begin
                next_idx <= '0;
                frame_step <= 1'b0;
            end
        end

        if (rst) begin
            next_idx <= '0;
            frame_step <= 1'b0;
            frame_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/tod_load_ctrl.sv */
// compares received frames against local time, counts mismatches and issues counter loads
`default_nettype none

`include "ptp_td_defs.svh"

module tod_load_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire ptp_td_pkg::tod_sec_t  frame_sec,
    input  wire ptp_td_pkg::tod_ns_t   frame_ns,
    input  wire logic                  frame_step,
    input  wire logic                  frame_valid,
    input  wire ptp_td_pkg::tod_sec_t  tod_sec,
    input  wire ptp_td_pkg::tod_ns_t   tod_ns,
    output logic                       load,
    output ptp_td_pkg::tod_sec_t       load_sec,
    output ptp_td_pkg::tod_ns_t        load_ns
);

    import ptp_td_pkg::*;

    mismatch_cnt_t mismatch_cnt;
    logic          reload_armed;
    logic          mismatch;

    // coarse compare, low ns bits are ignored
    assign mismatch = (frame_sec != tod_sec) ||
                      (frame_ns[29:`TOD_CMP_SHIFT] != tod_ns[29:`TOD_CMP_SHIFT]);

    always_ff @(posedge clk) begin
        load <= 1'b0;

        if (frame_valid) begin
            if (frame_step || reload_armed) begin
                load <= 1'b1;
                load_sec <= frame_sec;
                load_ns <= frame_ns;
                mismatch_cnt <= '0;
                reload_armed <= 1'b0;
            end else if (!mismatch) begin
                mismatch_cnt <= '0;
            end else if (mismatch_cnt == mismatch_cnt_t'(`MISMATCH_LIMIT)) begin
                // next frame is taken as is
                reload_armed <= 1'b1;
                mismatch_cnt <= '0;
            end else begin
                mismatch_cnt <= mismatch_cnt + 1'b1;
            end
        end

        if (rst) begin
            load <= 1'b0;
            mismatch_cnt <= '0;
            reload_armed <= 1'b0;
        end
    end

    a_load_after_frame: assert property (@(posedge clk) disable iff (rst)
        load |-> $past(frame_valid));

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/ptp_td_pkg.sv
design/td_deserializer.sv
design/tod_frame_decoder.sv
design/tod_load_ctrl.sv
design/tod_counter.sv
design/ptp_tod_leaf.sv
verif/tb_ptp_tod_leaf.sv

/* verif/tb_ptp_tod_leaf.sv */
// directed testbench top that sends serial frames into the time-of-day leaf and checks its outputs
`default_nettype none

`include "ptp_td_defs.svh"

module tb_ptp_tod_leaf;

    import ptp_td_pkg::*;

    // twice the length of 15 frames of about 110 cycles plus the free-running checks
    localparam int frame_cycles = 110;
    localparam int frame_count = 15;
    localparam int limit_time = (frame_count * frame_cycles + 300) * 4 * 2;
    // start bit plus six words of data and continuation
    localparam int frame_bits = 1 + 17 * 6;

    logic    clk;
    logic    rst;
    logic    sdi;
    tod_ts_t ts_tod;
    logic    tod_step;
    logic    pps;
    logic    pps_str;

    integer seed;
    int     errors;
    longint cyc;

    // reference time as seen at the sample point of cycle base_cyc
    tod_sec_t base_sec;
    tod_ns_t  base_ns;
    longint   base_cyc;
    int       ref_cnt;
    logic     ref_armed;
    logic     str_exp;

    ptp_tod_leaf ptp_tod_leaf_i (
        .clk(clk),
        .rst(rst),
        .sdi(sdi),
        .ts_tod(ts_tod),
        .tod_step(tod_step),
        .pps(pps),
        .pps_str(pps_str)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic tod_ts_t predict_ts(input longint c);
        longint   total;
        tod_sec_t sec;
        tod_ns_t  ns;
        total = longint'(base_ns) + (c - base_cyc) * `TOD_PERIOD_NS;
        sec = base_sec + tod_sec_t'(total / `NS_PER_S);
        ns = tod_ns_t'(total % `NS_PER_S);
        return {sec, 2'b00, ns};
    endfunction

    function automatic void set_base(input tod_sec_t sec, input tod_ns_t ns);
        base_sec = sec;
        base_ns = ns;
        base_cyc = cyc;
    endfunction

    // returns 1 when the load control takes the frame
    function automatic logic frame_loads(input tod_sec_t sec, input tod_ns_t ns,
                                         input logic step, input tod_ts_t local_ts);
        logic differ;
        differ = (sec != local_ts[79:32]) ||
                 (ns[29:`TOD_CMP_SHIFT] != local_ts[29:`TOD_CMP_SHIFT]);
        if (step || ref_armed) begin
            ref_cnt = 0;
            ref_armed = 1'b0;
            return 1'b1;
        end
        if (!differ) begin
            ref_cnt = 0;
        end else if (ref_cnt == `MISMATCH_LIMIT) begin
            ref_armed = 1'b1;
            ref_cnt = 0;
        end else begin
            ref_cnt++;
        end
        return 1'b0;
    endfunction

    function automatic tod_sec_t rand_sec();
        tod_sec_t s;
        s = {16'($random(seed)), 32'($random(seed))};
        return s;
    endfunction

    function automatic tod_ns_t rand_ns();
        tod_ns_t n;
        // keep clear of the rollover so no second ends inside a short check
        n = tod_ns_t'({$random(seed)} % (`NS_PER_S - 1000000));
        return n;
    endfunction

    task automatic check_ts(input string name, input tod_ts_t got, input tod_ts_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic drive_bit(input logic b);
        sdi = b;
        @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input msg_id_t msg, input tod_sec_t sec, input tod_ns_t ns,
                              input logic step, input int nwords);
        td_word_t words [6];
        words[0] = td_word_t'(msg);
        words[1] = ns[15:0];
        words[2] = td_word_t'(ns[29:16]);
        words[2][`TD_STEP_BIT] = step;
        words[3] = sec[15:0];
        words[4] = sec[31:16];
        words[5] = sec[47:32];
        drive_bit(1'b0);
        for (int w = 0; w < nwords; w++) begin
            for (int b = 0; b < `TD_WORD_W; b++) begin
                drive_bit(words[w][b]);
            end
            // continuation bit of 1 ends the frame
            drive_bit(w == nwords - 1);
        end
    endtask

    // sends a frame and checks the four cycles after its last edge
    task automatic frame_and_check(input msg_id_t msg, input tod_sec_t sec, input tod_ns_t ns,
                                   input logic step, input int nwords);
        tod_ts_t local_ts;
        logic    load_exp;
        send_frame(msg, sec, ns, step, nwords);
        // load control compares against the time one cycle after the last edge
        local_ts = predict_ts(cyc + 1);
        load_exp = 1'b0;
        if (msg == `TD_MSG_TOD && nwords == 6) begin
            load_exp = frame_loads(sec, ns, step, local_ts);
        end
        for (int k = 1; k <= 4; k++) begin
            @(posedge clk);
            #1;
            if (load_exp && k == 3) begin
                check_ts("ts_tod", ts_tod, {sec, 2'b00, ns});
                check_bit("tod_step", tod_step, 1'b1);
                set_base(sec, ns);
            end else begin
                check_ts("ts_tod", ts_tod, predict_ts(cyc));
                check_bit("tod_step", tod_step, 1'b0);
            end
        end
    endtask

    task automatic run_check(input int n);
        tod_ts_t prev;
        tod_ts_t exp;
        logic    pps_exp;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            prev = predict_ts(cyc - 1);
            exp = predict_ts(cyc);
            pps_exp = (exp[79:32] != prev[79:32]);
            if (prev[`PPS_STR_CLEAR_BIT]) begin
                str_exp = 1'b0;
            end
            if (pps_exp) begin
                str_exp = 1'b1;
            end
            check_ts("ts_tod", ts_tod, exp);
            check_bit("tod_step", tod_step, 1'b0);
            check_bit("pps", pps, pps_exp);
            check_bit("pps_str", pps_str, str_exp);
        end
    endtask

    task automatic reset_state();
        check_ts("ts_tod", ts_tod, '0);
        check_bit("tod_step", tod_step, 1'b0);
        check_bit("pps", pps, 1'b0);
        check_bit("pps_str", pps_str, 1'b0);
        run_check(12);
    endtask

    task automatic step_loads();
        for (int i = 0; i < 2; i++) begin
            frame_and_check(msg_id_t'(`TD_MSG_TOD), rand_sec(), rand_ns(), 1'b1, 6);
            run_check(8);
        end
    endtask

    task automatic second_rollover();
        tod_ts_t now;
        // off the period grid so the wrap leaves a remainder
        frame_and_check(msg_id_t'(`TD_MSG_TOD), rand_sec(),
                        tod_ns_t'(`NS_PER_S - 30 * `TOD_PERIOD_NS + 5), 1'b1, 6);
        run_check(40);
        check_bit("pps_str", pps_str, 1'b1);
        // jump to just below bit 29 while the stretch is still high
        now = predict_ts(cyc);
        frame_and_check(msg_id_t'(`TD_MSG_TOD), now[79:32],
                        tod_ns_t'((1 << `PPS_STR_CLEAR_BIT) - 12 * `TOD_PERIOD_NS), 1'b1, 6);
        check_bit("pps_str", pps_str, 1'b1);
        run_check(20);
        check_bit("pps_str", pps_str, 1'b0);
    endtask

    task automatic frame_compare();
        tod_ts_t now;
        for (int i = 0; i < 3; i++) begin
            // local time at the compare with one bit below the window flipped
            now = predict_ts(cyc + frame_bits + 1);
            frame_and_check(msg_id_t'(`TD_MSG_TOD), now[79:32],
                            now[29:0] ^ tod_ns_t'(1 << (`TOD_CMP_SHIFT - 1)), 1'b0, 6);
            run_check(5);
        end
        // four misses arm the reload and the fifth frame is taken
        for (int i = 0; i < 5; i++) begin
            frame_and_check(msg_id_t'(`TD_MSG_TOD), rand_sec(), rand_ns(), 1'b0, 6);
            run_check(5);
        end
    endtask

    task automatic ignored_frames();
        frame_and_check(msg_id_t'(1), rand_sec(), rand_ns(), 1'b0, 6);
        run_check(4);
        frame_and_check(msg_id_t'(`TD_MSG_TOD), rand_sec(), rand_ns(), 1'b1, 4);
        run_check(4);
        frame_and_check(msg_id_t'(1), rand_sec(), rand_ns(), 1'b1, 6);
        run_check(4);
    endtask

    initial begin
        seed = 32'hbe7c1062;
        errors = 0;
        cyc = 0;
        ref_cnt = 0;
        ref_armed = 1'b0;
        str_exp = 1'b0;
        clk = 1'b0;
        rst = 1'b1;
        sdi = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        set_base('0, '0);
        reset_state();
        step_loads();
        second_rollover();
        frame_compare();
        ignored_frames();
        $display("tests done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(limit_time);
        $display("timeout after %0d time units, tests did not finish, errors: %0d",
                 limit_time, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
